// File: common/memctrl_pkg.sv
// Shared operation encodings and default cache geometry
// Geometry defaults are only defaults; the top level passes its own values down
// Set, way and word counts are expected to be powers of two of at least 2
package memctrl_pkg;

    // Directory operation of the current cycle
    typedef enum logic [1:0] {
        DIR_IDLE   = 2'd0,
        DIR_CLEAR  = 2'd1,
        DIR_LOOKUP = 2'd2,
        DIR_REFILL = 2'd3
    } dir_op_e;

    // Data array operation of the current cycle
    typedef enum logic [1:0] {
        DATA_IDLE   = 2'd0,
        DATA_READ   = 2'd1,
        DATA_WRITE  = 2'd2,
        DATA_REFILL = 2'd3
    } data_op_e;

    // Default geometry
    localparam int unsigned DEF_NUM_WAYS   = 4;
    localparam int unsigned DEF_NUM_SETS   = 16;
    localparam int unsigned DEF_TAG_WIDTH  = 20;
    localparam int unsigned DEF_WORD_WIDTH = 32;
    localparam int unsigned DEF_LINE_WORDS = 4;

endpackage

// File: data/data_ctrl.sv
`timescale 1ns/1ps
// Data array request selection and read-way multiplexing
// Refill beats write, write beats read; every write is a full word
// A read is issued with its lookup, its word is picked by the next-cycle hit vector
module data_ctrl
    import memctrl_pkg::*;
#(
    parameter int unsigned NUM_WAYS   = DEF_NUM_WAYS,
    parameter int unsigned NUM_SETS   = DEF_NUM_SETS,
    parameter int unsigned WORD_WIDTH = DEF_WORD_WIDTH,
    parameter int unsigned LINE_WORDS = DEF_LINE_WORDS,
    localparam int unsigned SET_W     = $clog2(NUM_SETS),
    localparam int unsigned WIDX_W    = $clog2(LINE_WORDS),
    localparam int unsigned ADDR_W    = $clog2(NUM_SETS * LINE_WORDS)
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                data_read_i,
    input  logic [SET_W-1:0]                    data_read_set_i,
    input  logic [WIDX_W-1:0]                   data_read_word_i,
    input  logic                                data_write_i,
    input  logic [SET_W-1:0]                    data_write_set_i,
    input  logic [WIDX_W-1:0]                   data_write_word_i,
    input  logic [WORD_WIDTH-1:0]               data_write_data_i,
    input  logic                                data_refill_i,
    input  logic [SET_W-1:0]                    data_refill_set_i,
    input  logic [NUM_WAYS-1:0]                 data_refill_way_i,
    input  logic [WIDX_W-1:0]                   data_refill_word_i,
    input  logic [WORD_WIDTH-1:0]               data_refill_data_i,
    input  logic [NUM_WAYS-1:0]                 hit_way_i,
    input  logic [NUM_WAYS-1:0][WORD_WIDTH-1:0] rdata_i,
    output logic [ADDR_W-1:0]                   data_addr_o,
    output logic [NUM_WAYS-1:0]                 data_cs_o,
    output logic [NUM_WAYS-1:0]                 data_we_o,
    output logic [WORD_WIDTH-1:0]               data_wdata_o,
    output logic [WORD_WIDTH-1:0]               data_read_data_o
);

    data_op_e op;
    logic     read_q;

    // Row of a word: set * LINE_WORDS + word
    function automatic logic [ADDR_W-1:0] line_addr(
        input logic [SET_W-1:0]  set,
        input logic [WIDX_W-1:0] word
    );
        return ADDR_W'(set) * ADDR_W'(LINE_WORDS) + ADDR_W'(word);
    endfunction

    always_comb begin
        if (data_refill_i) begin
            op = DATA_REFILL;
        end else if (data_write_i) begin
            op = DATA_WRITE;
        end else if (data_read_i) begin
            op = DATA_READ;
        end else begin
            op = DATA_IDLE;
        end
    end

    always_comb begin
        data_addr_o  = '0;
        data_cs_o    = '0;
        data_we_o    = '0;
        data_wdata_o = data_write_data_i;
        case (op)
            DATA_REFILL: begin
                data_addr_o  = line_addr(data_refill_set_i, data_refill_word_i);
                data_cs_o    = data_refill_way_i;
                data_we_o    = data_refill_way_i;
                data_wdata_o = data_refill_data_i;
            end
            DATA_WRITE: begin
                // Way of the previous lookup; a miss writes nothing
                data_addr_o = line_addr(data_write_set_i, data_write_word_i);
                data_cs_o   = hit_way_i;
                data_we_o   = hit_way_i;
            end
            DATA_READ: begin
                data_addr_o = line_addr(data_read_set_i, data_read_word_i);
                data_cs_o   = '1;
            end
            default: begin
                data_addr_o = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            read_q <= 1'b0;
        end else begin
            read_q <= (op == DATA_READ);
        end
    end

    // One-hot select, so OR-ing the masked words is enough
    always_comb begin
        data_read_data_o = '0;
        for (int w = 0; w < int'(NUM_WAYS); w++) begin
            if (read_q && hit_way_i[w]) begin
                data_read_data_o = data_read_data_o | rdata_i[w];
            end
        end
    end

    data_strobe_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({data_read_i, data_write_i, data_refill_i}))
        else $error("data_ctrl: more than one data access in the same cycle");

endmodule

// File: dir/dir_req_mux.sv
`timescale 1ns/1ps
// Directory request selection and the clear sequence after reset
// ready_o rises NUM_SETS cycles after reset release, once all sets are cleared
// Callers keep every directory strobe low until ready_o
module dir_req_mux
    import memctrl_pkg::*;
#(
    parameter int unsigned NUM_WAYS  = DEF_NUM_WAYS,
    parameter int unsigned NUM_SETS  = DEF_NUM_SETS,
    parameter int unsigned TAG_WIDTH = DEF_TAG_WIDTH,
    localparam int unsigned SET_W    = $clog2(NUM_SETS)
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 dir_match_i,
    input  logic [SET_W-1:0]     dir_match_set_i,
    input  logic                 dir_refill_i,
    input  logic [SET_W-1:0]     dir_refill_set_i,
    input  logic [NUM_WAYS-1:0]  dir_refill_way_i,
    input  logic [TAG_WIDTH-1:0] dir_refill_tag_i,
    output logic                 ready_o,
    output dir_op_e              dir_op_o,
    output logic [SET_W-1:0]     dir_addr_o,
    output logic [NUM_WAYS-1:0]  dir_cs_o,
    output logic [NUM_WAYS-1:0]  dir_we_o,
    output logic [TAG_WIDTH:0]   dir_wentry_o
);

    logic [SET_W-1:0] clr_set_q;
    logic             done_q;

    // Clear sequencer, one set per cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            clr_set_q <= '0;
            done_q    <= 1'b0;
        end else if (!done_q) begin
            clr_set_q <= clr_set_q + 1'b1;
            done_q    <= (clr_set_q == SET_W'(NUM_SETS - 1));
        end
    end

    assign ready_o = done_q;

    always_comb begin
        dir_op_o     = DIR_IDLE;
        dir_addr_o   = dir_match_set_i;
        dir_cs_o     = '0;
        dir_we_o     = '0;
        dir_wentry_o = '0;
        if (!done_q) begin
            // Invalid entries into every way
            dir_op_o   = DIR_CLEAR;
            dir_addr_o = clr_set_q;
            dir_cs_o   = '1;
            dir_we_o   = '1;
        end else if (dir_match_i) begin
            dir_op_o = DIR_LOOKUP;
            dir_cs_o = '1;
        end else if (dir_refill_i) begin
            // Only the chosen way is touched
            dir_op_o     = DIR_REFILL;
            dir_addr_o   = dir_refill_set_i;
            dir_cs_o     = dir_refill_way_i;
            dir_we_o     = dir_refill_way_i;
            dir_wentry_o = {1'b1, dir_refill_tag_i};
        end
    end

    dir_strobe_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({dir_match_i, dir_refill_i}))
        else $error("dir_req_mux: lookup and refill in the same cycle");

    dir_strobe_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !ready_o |-> !(dir_match_i || dir_refill_i))
        else $error("dir_req_mux: directory strobe while the clear is running");

endmodule

// File: dir/dir_resolve.sv
`timescale 1ns/1ps
// Hit vector and victim choice from the per-way results of the last lookup
// Victim is the lowest invalid way, else the rotating pointer
// Both outputs stay zero until the first lookup after reset
module dir_resolve
    import memctrl_pkg::*;
#(
    parameter int unsigned NUM_WAYS = DEF_NUM_WAYS,
    localparam int unsigned PTR_W   = $clog2(NUM_WAYS)
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  dir_op_e             dir_op_i,
    input  logic [NUM_WAYS-1:0] hit_i,
    input  logic [NUM_WAYS-1:0] valid_i,
    output logic [NUM_WAYS-1:0] dir_hit_way_o,
    output logic [NUM_WAYS-1:0] dir_victim_way_o
);

    logic                looked_q;
    logic [PTR_W-1:0]    rr_ptr_q;
    logic [NUM_WAYS-1:0] victim;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            looked_q <= 1'b0;
            rr_ptr_q <= '0;
        end else begin
            if (dir_op_i == DIR_LOOKUP) begin
                looked_q <= 1'b1;
            end
            // One step per refill, wrapping at the last way
            if (dir_op_i == DIR_REFILL) begin
                rr_ptr_q <= (rr_ptr_q == PTR_W'(NUM_WAYS - 1)) ? '0 : rr_ptr_q + 1'b1;
            end
        end
    end

    always_comb begin
        victim           = '0;
        victim[rr_ptr_q] = 1'b1;
        // Scan downwards so the lowest invalid way wins
        for (int w = int'(NUM_WAYS) - 1; w >= 0; w--) begin
            if (!valid_i[w]) begin
                victim    = '0;
                victim[w] = 1'b1;
            end
        end
    end

    assign dir_hit_way_o    = looked_q ? hit_i : '0;
    assign dir_victim_way_o = looked_q ? victim : '0;

    // A tag may live in one way of a set only
    hit_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(dir_hit_way_o))
        else $error("dir_resolve: tag hits in more than one way");

endmodule

// File: dir/dir_way.sv
`timescale 1ns/1ps
// One directory way: entry RAM, lookup tag register and tag compare
// hit_o and valid_o reflect the set of the last lookup, one cycle later
module dir_way
    import memctrl_pkg::*;
#(
    parameter int unsigned NUM_SETS  = DEF_NUM_SETS,
    parameter int unsigned TAG_WIDTH = DEF_TAG_WIDTH,
    localparam int unsigned SET_W    = $clog2(NUM_SETS)
) (
    input  logic                 clk_i,
    input  logic                 cs_i,
    input  logic                 we_i,
    input  logic [SET_W-1:0]     addr_i,
    input  logic [TAG_WIDTH:0]   wentry_i,
    input  logic [TAG_WIDTH-1:0] tag_i,
    output logic                 hit_o,
    output logic                 valid_o
);

    typedef struct packed {
        logic                 valid;
        logic [TAG_WIDTH-1:0] tag;
    } dir_entry_t;

    dir_entry_t           rentry;
    logic [TAG_WIDTH-1:0] tag_q;

    cache_sram #(
        .DEPTH   (NUM_SETS),
        .entry_t (dir_entry_t)
    ) u_dir_ram (
        .clk_i   (clk_i),
        .cs_i    (cs_i),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .wdata_i (dir_entry_t'(wentry_i)),
        .rdata_o (rentry)
    );

    // Lookup tag lines up with the entry read in the same cycle
    always_ff @(posedge clk_i) begin
        if (cs_i && !we_i) begin
            tag_q <= tag_i;
        end
    end

    assign valid_o = rentry.valid;
    assign hit_o   = rentry.valid && (rentry.tag == tag_q);

endmodule

// File: memctrl.f
common/memctrl_pkg.sv
src/cache_sram.sv
dir/dir_req_mux.sv
dir/dir_way.sv
dir/dir_resolve.sv
data/data_ctrl.sv
src/memctrl_top.sv
tests/tb_memctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator, run the testbench and judge the log
cd "$(dirname "$0")" || exit 1
mkdir -p build || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_memctrl \
    -f memctrl.f --Mdir build -o sim_memctrl > build/compile.log 2>&1 \
    || { cat build/compile.log; echo "compile step failed"; exit 1; }

./build/sim_memctrl > build/sim.log 2>&1
cat build/sim.log

grep -q ">>> FAIL" build/sim.log && exit 1
grep -q ">>> PASS" build/sim.log || { echo "run ended without a verdict"; exit 1; }
exit 0

// File: src/cache_sram.sv
`timescale 1ns/1ps
// Single-port synchronous RAM, one access per cycle
// Read data appears one cycle after a chip-selected read and holds otherwise
// Contents are undefined after power-up; callers clear what they rely on
module cache_sram #(
    parameter int unsigned DEPTH   = 16,
    parameter type         entry_t = logic [31:0],
    localparam int unsigned ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk_i,
    input  logic              cs_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  entry_t            wdata_i,
    output entry_t            rdata_o
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk_i) begin
        if (cs_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

    // Write strobes must come with a chip select from the request muxes
    we_needs_cs_a: assert property (@(posedge clk_i) we_i |-> cs_i)
        else $error("cache_sram: write enable without chip select");

endmodule

// File: src/memctrl_top.sv
`timescale 1ns/1ps
// Directory and data array controller for a set-associative cache
// No handshake: strobes are one-hot per array and wait for ready_o
// Lookup results and read data arrive one cycle after their strobe
module memctrl_top
    import memctrl_pkg::*;
#(
    parameter int unsigned NUM_WAYS   = DEF_NUM_WAYS,
    parameter int unsigned NUM_SETS   = DEF_NUM_SETS,
    parameter int unsigned TAG_WIDTH  = DEF_TAG_WIDTH,
    parameter int unsigned WORD_WIDTH = DEF_WORD_WIDTH,
    parameter int unsigned LINE_WORDS = DEF_LINE_WORDS,
    localparam int unsigned SET_W     = $clog2(NUM_SETS),
    localparam int unsigned WIDX_W    = $clog2(LINE_WORDS),
    localparam int unsigned ADDR_W    = $clog2(NUM_SETS * LINE_WORDS)
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    output logic                  ready_o,
    input  logic                  dir_match_i,
    input  logic [SET_W-1:0]      dir_match_set_i,
    input  logic [TAG_WIDTH-1:0]  dir_match_tag_i,
    input  logic                  dir_refill_i,
    input  logic [SET_W-1:0]      dir_refill_set_i,
    input  logic [NUM_WAYS-1:0]   dir_refill_way_i,
    input  logic [TAG_WIDTH-1:0]  dir_refill_tag_i,
    output logic [NUM_WAYS-1:0]   dir_hit_way_o,
    output logic [NUM_WAYS-1:0]   dir_victim_way_o,
    input  logic                  data_read_i,
    input  logic [SET_W-1:0]      data_read_set_i,
    input  logic [WIDX_W-1:0]     data_read_word_i,
    output logic [WORD_WIDTH-1:0] data_read_data_o,
    input  logic                  data_write_i,
    input  logic [SET_W-1:0]      data_write_set_i,
    input  logic [WIDX_W-1:0]     data_write_word_i,
    input  logic [WORD_WIDTH-1:0] data_write_data_i,
    input  logic                  data_refill_i,
    input  logic [SET_W-1:0]      data_refill_set_i,
    input  logic [NUM_WAYS-1:0]   data_refill_way_i,
    input  logic [WIDX_W-1:0]     data_refill_word_i,
    input  logic [WORD_WIDTH-1:0] data_refill_data_i
);

    dir_op_e                             dir_op;
    logic [SET_W-1:0]                    dir_addr;
    logic [NUM_WAYS-1:0]                 dir_cs;
    logic [NUM_WAYS-1:0]                 dir_we;
    logic [TAG_WIDTH:0]                  dir_wentry;
    logic [NUM_WAYS-1:0]                 way_hit;
    logic [NUM_WAYS-1:0]                 way_valid;
    logic [ADDR_W-1:0]                   data_addr;
    logic [NUM_WAYS-1:0]                 data_cs;
    logic [NUM_WAYS-1:0]                 data_we;
    logic [WORD_WIDTH-1:0]               data_wdata;
    logic [NUM_WAYS-1:0][WORD_WIDTH-1:0] data_rdata;

    dir_req_mux #(
        .NUM_WAYS         (NUM_WAYS),
        .NUM_SETS         (NUM_SETS),
        .TAG_WIDTH        (TAG_WIDTH)
    ) u_dir_req_mux (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .dir_match_i      (dir_match_i),
        .dir_match_set_i  (dir_match_set_i),
        .dir_refill_i     (dir_refill_i),
        .dir_refill_set_i (dir_refill_set_i),
        .dir_refill_way_i (dir_refill_way_i),
        .dir_refill_tag_i (dir_refill_tag_i),
        .ready_o          (ready_o),
        .dir_op_o         (dir_op),
        .dir_addr_o       (dir_addr),
        .dir_cs_o         (dir_cs),
        .dir_we_o         (dir_we),
        .dir_wentry_o     (dir_wentry)
    );

    for (genvar w = 0; w < int'(NUM_WAYS); w++) begin : gen_dir_way
        dir_way #(
            .NUM_SETS  (NUM_SETS),
            .TAG_WIDTH (TAG_WIDTH)
        ) u_dir_way (
            .clk_i     (clk_i),
            .cs_i      (dir_cs[w]),
            .we_i      (dir_we[w]),
            .addr_i    (dir_addr),
            .wentry_i  (dir_wentry),
            .tag_i     (dir_match_tag_i),
            .hit_o     (way_hit[w]),
            .valid_o   (way_valid[w])
        );
    end

    dir_resolve #(
        .NUM_WAYS         (NUM_WAYS)
    ) u_dir_resolve (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .dir_op_i         (dir_op),
        .hit_i            (way_hit),
        .valid_i          (way_valid),
        .dir_hit_way_o    (dir_hit_way_o),
        .dir_victim_way_o (dir_victim_way_o)
    );

    data_ctrl #(
        .NUM_WAYS           (NUM_WAYS),
        .NUM_SETS           (NUM_SETS),
        .WORD_WIDTH         (WORD_WIDTH),
        .LINE_WORDS         (LINE_WORDS)
    ) u_data_ctrl (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .data_read_i        (data_read_i),
        .data_read_set_i    (data_read_set_i),
        .data_read_word_i   (data_read_word_i),
        .data_write_i       (data_write_i),
        .data_write_set_i   (data_write_set_i),
        .data_write_word_i  (data_write_word_i),
        .data_write_data_i  (data_write_data_i),
        .data_refill_i      (data_refill_i),
        .data_refill_set_i  (data_refill_set_i),
        .data_refill_way_i  (data_refill_way_i),
        .data_refill_word_i (data_refill_word_i),
        .data_refill_data_i (data_refill_data_i),
        .hit_way_i          (dir_hit_way_o),
        .rdata_i            (data_rdata),
        .data_addr_o        (data_addr),
        .data_cs_o          (data_cs),
        .data_we_o          (data_we),
        .data_wdata_o       (data_wdata),
        .data_read_data_o   (data_read_data_o)
    );

    for (genvar w = 0; w < int'(NUM_WAYS); w++) begin : gen_data_ram
        cache_sram #(
            .DEPTH   (NUM_SETS * LINE_WORDS),
            .entry_t (logic [WORD_WIDTH-1:0])
        ) u_data_ram (
            .clk_i   (clk_i),
            .cs_i    (data_cs[w]),
            .we_i    (data_we[w]),
            .addr_i  (data_addr),
            .wdata_i (data_wdata),
            .rdata_o (data_rdata[w])
        );
    end

endmodule

// File: tests/tb_memctrl.sv
`timescale 1ns/1ps
// Testbench for the cache directory and data controller, default geometry only
// A reference model mirrors directory entries, data words and the replacement pointer
// Checks sample on the falling edge after each strobe, when the registered outputs are stable
module tb_memctrl
    import memctrl_pkg::*;
();

    localparam int unsigned NUM_WAYS      = DEF_NUM_WAYS;
    localparam int unsigned NUM_SETS      = DEF_NUM_SETS;
    localparam int unsigned TAG_WIDTH     = DEF_TAG_WIDTH;
    localparam int unsigned WORD_WIDTH    = DEF_WORD_WIDTH;
    localparam int unsigned LINE_WORDS    = DEF_LINE_WORDS;
    localparam int unsigned SET_W         = $clog2(NUM_SETS);
    localparam int unsigned WIDX_W        = $clog2(LINE_WORDS);
    localparam int unsigned READY_TIMEOUT = 100;

    logic                  clk_i = 1'b0;
    logic                  rst_ni;
    logic                  ready_o;
    logic                  dir_match_i;
    logic [SET_W-1:0]      dir_match_set_i;
    logic [TAG_WIDTH-1:0]  dir_match_tag_i;
    logic                  dir_refill_i;
    logic [SET_W-1:0]      dir_refill_set_i;
    logic [NUM_WAYS-1:0]   dir_refill_way_i;
    logic [TAG_WIDTH-1:0]  dir_refill_tag_i;
    logic [NUM_WAYS-1:0]   dir_hit_way_o;
    logic [NUM_WAYS-1:0]   dir_victim_way_o;
    logic                  data_read_i;
    logic [SET_W-1:0]      data_read_set_i;
    logic [WIDX_W-1:0]     data_read_word_i;
    logic [WORD_WIDTH-1:0] data_read_data_o;
    logic                  data_write_i;
    logic [SET_W-1:0]      data_write_set_i;
    logic [WIDX_W-1:0]     data_write_word_i;
    logic [WORD_WIDTH-1:0] data_write_data_i;
    logic                  data_refill_i;
    logic [SET_W-1:0]      data_refill_set_i;
    logic [NUM_WAYS-1:0]   data_refill_way_i;
    logic [WIDX_W-1:0]     data_refill_word_i;
    logic [WORD_WIDTH-1:0] data_refill_data_i;

    // Reference model
    logic                  mdl_valid [NUM_SETS][NUM_WAYS];
    logic [TAG_WIDTH-1:0]  mdl_tag   [NUM_SETS][NUM_WAYS];
    logic [WORD_WIDTH-1:0] mdl_data  [NUM_SETS][NUM_WAYS][LINE_WORDS];
    int unsigned           mdl_ptr;
    logic [NUM_WAYS-1:0]   last_hit;
    int                    seed = 86200;
    int unsigned           tag_cnt;
    int unsigned           edges;

    // Expectations set with the strobe, then held for one cycle
    string                 test_name;
    logic                  lookup_chk;
    logic                  read_chk;
    logic [NUM_WAYS-1:0]   hit_exp;
    logic [NUM_WAYS-1:0]   victim_exp;
    logic [WORD_WIDTH-1:0] rdata_exp;
    string                 name_q;
    logic                  lookup_chk_q;
    logic                  read_chk_q;
    logic [NUM_WAYS-1:0]   hit_exp_q;
    logic [NUM_WAYS-1:0]   victim_exp_q;
    logic [WORD_WIDTH-1:0] rdata_exp_q;

    memctrl_top DUT (.*);

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            edges <= 0;
        end else begin
            edges <= edges + 1;
        end
    end

    always @(posedge clk_i) begin
        name_q       <= test_name;
        lookup_chk_q <= lookup_chk;
        read_chk_q   <= read_chk;
        hit_exp_q    <= hit_exp;
        victim_exp_q <= victim_exp;
        rdata_exp_q  <= rdata_exp;
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        $display("ERR %s expected %0h actual %0h", name, exp_v, act_v);
        $display(">>> FAIL");
        $fatal(1, "mismatch in %s", name);
    endtask

    // Clear sequence takes exactly one edge per set
    ready_time_a: assert property (@(negedge clk_i) disable iff (!rst_ni)
        ready_o == (edges >= NUM_SETS))
        else report_mismatch(name_q, 64'(edges >= NUM_SETS), 64'(ready_o));

    idle_outputs_a: assert property (@(negedge clk_i) disable iff (!rst_ni)
        !ready_o |-> {dir_hit_way_o, dir_victim_way_o} == '0)
        else report_mismatch(name_q, 64'(0), 64'({dir_hit_way_o, dir_victim_way_o}));

    hit_a: assert property (@(negedge clk_i) disable iff (!rst_ni)
        lookup_chk_q |-> dir_hit_way_o == hit_exp_q)
        else report_mismatch(name_q, 64'(hit_exp_q), 64'(dir_hit_way_o));

    victim_a: assert property (@(negedge clk_i) disable iff (!rst_ni)
        lookup_chk_q |-> dir_victim_way_o == victim_exp_q)
        else report_mismatch(name_q, 64'(victim_exp_q), 64'(dir_victim_way_o));

    read_a: assert property (@(negedge clk_i) disable iff (!rst_ni)
        read_chk_q |-> data_read_data_o == rdata_exp_q)
        else report_mismatch(name_q, 64'(rdata_exp_q), 64'(data_read_data_o));

    // Counter in the low byte keeps every tag unique
    function automatic logic [TAG_WIDTH-1:0] next_tag();
        logic [31:0] r;
        r = $random(seed);
        tag_cnt++;
        return {r[TAG_WIDTH-1:8], tag_cnt[7:0]};
    endfunction

    function automatic int unsigned way_index(input logic [NUM_WAYS-1:0] vec);
        int unsigned idx;
        idx = 0;
        for (int w = 0; w < int'(NUM_WAYS); w++) begin
            if (vec[w]) begin
                idx = w;
            end
        end
        return idx;
    endfunction

    function automatic logic [NUM_WAYS-1:0] model_hit(input int unsigned set,
                                                      input logic [TAG_WIDTH-1:0] tag);
        logic [NUM_WAYS-1:0] h;
        h = '0;
        for (int w = 0; w < int'(NUM_WAYS); w++) begin
            h[w] = mdl_valid[set][w] && (mdl_tag[set][w] == tag);
        end
        return h;
    endfunction

    // First free way, otherwise the pointer
    function automatic logic [NUM_WAYS-1:0] model_victim(input int unsigned set);
        logic [NUM_WAYS-1:0] v;
        v = '0;
        for (int w = 0; w < int'(NUM_WAYS); w++) begin
            if (!mdl_valid[set][w] && v == '0) begin
                v[w] = 1'b1;
            end
        end
        if (v == '0) begin
            v[mdl_ptr] = 1'b1;
        end
        return v;
    endfunction

    task automatic idle_inputs();
        dir_match_i   = 1'b0;
        dir_refill_i  = 1'b0;
        data_read_i   = 1'b0;
        data_write_i  = 1'b0;
        data_refill_i = 1'b0;
        lookup_chk    = 1'b0;
        read_chk      = 1'b0;
    endtask

    task automatic wait_ready();
        int unsigned cycles;
        cycles = 0;
        while (!ready_o) begin
            if (cycles == READY_TIMEOUT) begin
                $display("timeout: ready_o still low %0d cycles after reset", cycles);
                $display(">>> FAIL");
                $fatal(1, "ready_o never rose");
            end
            cycles++;
            @(negedge clk_i);
        end
    endtask

    // Lookup, optionally paired with a read of the same set
    task automatic lookup(input int unsigned set, input logic [TAG_WIDTH-1:0] tag,
                          input bit with_read, input int unsigned word);
        idle_inputs();
        dir_match_i     = 1'b1;
        dir_match_set_i = SET_W'(set);
        dir_match_tag_i = tag;
        hit_exp         = model_hit(set, tag);
        victim_exp      = model_victim(set);
        lookup_chk      = 1'b1;
        last_hit        = hit_exp;
        if (with_read) begin
            data_read_i      = 1'b1;
            data_read_set_i  = SET_W'(set);
            data_read_word_i = WIDX_W'(word);
            rdata_exp        = '0;
            for (int w = 0; w < int'(NUM_WAYS); w++) begin
                if (hit_exp[w]) begin
                    rdata_exp = mdl_data[set][w][word];
                end
            end
            read_chk = 1'b1;
        end
        @(negedge clk_i);
    endtask

    task automatic dir_fill(input int unsigned set, input int unsigned way,
                            input logic [TAG_WIDTH-1:0] tag);
        idle_inputs();
        dir_refill_i        = 1'b1;
        dir_refill_set_i    = SET_W'(set);
        dir_refill_way_i    = NUM_WAYS'(1) << way;
        dir_refill_tag_i    = tag;
        mdl_valid[set][way] = 1'b1;
        mdl_tag[set][way]   = tag;
        mdl_ptr             = (mdl_ptr + 1) % NUM_WAYS;
        @(negedge clk_i);
    endtask

    task automatic data_fill(input int unsigned set, input int unsigned way,
                             input int unsigned word, input logic [WORD_WIDTH-1:0] data);
        idle_inputs();
        data_refill_i            = 1'b1;
        data_refill_set_i        = SET_W'(set);
        data_refill_way_i        = NUM_WAYS'(1) << way;
        data_refill_word_i       = WIDX_W'(word);
        data_refill_data_i       = data;
        mdl_data[set][way][word] = data;
        @(negedge clk_i);
    endtask

    // Goes to the way of the previous lookup, nowhere on a miss
    task automatic data_write(input int unsigned set, input int unsigned word,
                              input logic [WORD_WIDTH-1:0] data);
        idle_inputs();
        data_write_i      = 1'b1;
        data_write_set_i  = SET_W'(set);
        data_write_word_i = WIDX_W'(word);
        data_write_data_i = data;
        for (int w = 0; w < int'(NUM_WAYS); w++) begin
            if (last_hit[w]) begin
                mdl_data[set][w][word] = data;
            end
        end
        @(negedge clk_i);
    endtask

    initial begin
        int unsigned          set_a;
        int unsigned          way_a;
        int unsigned          set_b;
        int unsigned          vic;
        int unsigned          wr_word;
        logic [TAG_WIDTH-1:0] tag_a;
        rst_ni             = 1'b0;
        dir_match_set_i    = '0;
        dir_match_tag_i    = '0;
        dir_refill_set_i   = '0;
        dir_refill_way_i   = '0;
        dir_refill_tag_i   = '0;
        data_read_set_i    = '0;
        data_read_word_i   = '0;
        data_write_set_i   = '0;
        data_write_word_i  = '0;
        data_write_data_i  = '0;
        data_refill_set_i  = '0;
        data_refill_way_i  = '0;
        data_refill_word_i = '0;
        data_refill_data_i = '0;
        hit_exp            = '0;
        victim_exp         = '0;
        rdata_exp          = '0;
        idle_inputs();
        for (int s = 0; s < int'(NUM_SETS); s++) begin
            for (int w = 0; w < int'(NUM_WAYS); w++) begin
                mdl_valid[s][w] = 1'b0;
                mdl_tag[s][w]   = '0;
            end
        end
        mdl_ptr   = 0;
        last_hit  = '0;
        tag_cnt   = 0;
        test_name = "reset_clear";
        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;
        wait_ready();
        for (int s = 0; s < int'(NUM_SETS); s++) begin
            lookup(s, next_tag(), 1'b0, 0);
        end

        test_name = "refill_lookup";
        set_a = $unsigned($random(seed)) % NUM_SETS;
        way_a = $unsigned($random(seed)) % NUM_WAYS;
        tag_a = next_tag();
        dir_fill(set_a, way_a, tag_a);
        lookup(set_a, tag_a, 1'b0, 0);
        lookup(set_a, next_tag(), 1'b0, 0);

        // Fill every way of a second set, then keep replacing
        test_name = "victim_choice";
        set_b = (set_a + 1 + $unsigned($random(seed)) % (NUM_SETS - 1)) % NUM_SETS;
        for (int i = 0; i < int'(NUM_WAYS) + 6; i++) begin
            lookup(set_b, next_tag(), 1'b0, 0);
            vic = way_index(dir_victim_way_o);
            dir_fill(set_b, vic, next_tag());
        end
        lookup(set_b, next_tag(), 1'b0, 0);

        test_name = "data_refill_read";
        for (int k = 0; k < int'(LINE_WORDS); k++) begin
            data_fill(set_a, way_a, k, $random(seed));
        end
        for (int k = 0; k < int'(LINE_WORDS); k++) begin
            lookup(set_a, tag_a, 1'b1, k);
        end
        for (int k = 0; k < int'(LINE_WORDS); k++) begin
            lookup(set_a, next_tag(), 1'b1, k);
        end

        test_name = "write_hit";
        wr_word = $unsigned($random(seed)) % LINE_WORDS;
        for (int w = 0; w < int'(NUM_WAYS); w++) begin
            data_fill(set_b, w, wr_word, $random(seed));
        end
        vic = $unsigned($random(seed)) % NUM_WAYS;
        lookup(set_b, mdl_tag[set_b][vic], 1'b0, 0);
        data_write(set_b, wr_word, $random(seed));
        lookup(set_b, next_tag(), 1'b0, 0);
        data_write(set_b, wr_word, $random(seed));
        for (int w = 0; w < int'(NUM_WAYS); w++) begin
            lookup(set_b, mdl_tag[set_b][w], 1'b1, wr_word);
        end

        idle_inputs();
        repeat (2) @(negedge clk_i);
        $display(">>> PASS");
        $finish;
    end

endmodule
